// ==== aluUnit.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module aluUnit (
    input  logic              clk,
    input  logic              reset,
    input  execPkg::word_t    a,
    input  execPkg::word_t    b,
    input  execPkg::aluFunc_t aluFunc,
    input  logic              wordMode,
    input  logic              opValid,
    output execPkg::word_t    result,
    output logic              bubble
);
    localparam int unsigned     CNT_W    = $clog2(`EXEC_MUL_CYCLES);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`EXEC_MUL_CYCLES - 1);

    execPkg::word_t   full, prod;
    logic [31:0]      w;
    logic [CNT_W-1:0] cnt;
    logic             mulOp;

    // ==================================================
    // Multiplier sequencing
    // ==================================================
    assign mulOp  = opValid && (aluFunc == execPkg::MULLO);
    assign bubble = mulOp && (cnt != LAST_CNT); // Product is ready on the last count

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (mulOp) begin
            cnt <= (cnt == LAST_CNT) ? '0 : cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mulOp) prod <= a * b;    // Operands are held by decode while busy
    end

    // ==================================================
    // Result selection
    // ==================================================
    always_comb begin
        case (aluFunc)
            execPkg::ADD:   full = a + b;
            execPkg::SUB:   full = a - b;
            execPkg::AND:   full = a & b;
            execPkg::OR:    full = a | b;
            execPkg::XOR:   full = a ^ b;
            execPkg::SLL:   full = a << b[5:0];
            execPkg::SRL:   full = a >> b[5:0];
            execPkg::SRA:   full = $signed(a) >>> b[5:0];
            execPkg::SLT:   full = execPkg::word_t'($signed(a) < $signed(b));
            execPkg::SLTU:  full = execPkg::word_t'(a < b);
            execPkg::SEQ:   full = execPkg::word_t'(a == b);
            execPkg::PASSB: full = b;
            default:        full = prod;
        endcase
    end

    // Word forms only need the 32-bit add, sub and shifts
    always_comb begin
        case (aluFunc)
            execPkg::ADD: w = a[31:0] + b[31:0];
            execPkg::SUB: w = a[31:0] - b[31:0];
            execPkg::SLL: w = a[31:0] << b[4:0];
            execPkg::SRL: w = a[31:0] >> b[4:0];
            execPkg::SRA: w = $signed(a[31:0]) >>> b[4:0];
            default:      w = full[31:0];
        endcase
    end

    assign result = wordMode ? {{(`EXEC_XLEN-32){w[31]}}, w} : full;

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module decodeStage (
    input  logic              clk,
    input  logic              reset,
    input  logic              inValid,
    input  execPkg::u32       instr,
    input  execPkg::word_t    pc,
    input  execPkg::word_t    rs1Val,
    input  execPkg::word_t    rs2Val,
    input  execPkg::regIdx_t  dst,
    input  logic              stall,
    output logic              dValid,
    output execPkg::word_t    dPc,
    output execPkg::u32       dInstr,
    output execPkg::opClass_t dOp,
    output execPkg::aluFunc_t dAluFunc,
    output execPkg::word_t    dSrcA,
    output execPkg::word_t    dSrcB,
    output execPkg::word_t    dRs1,
    output execPkg::word_t    dRs2,
    output execPkg::regIdx_t  dDst
);
    execPkg::opClass_t nOp;
    execPkg::aluFunc_t nFunc;
    execPkg::word_t    nSrcA, nSrcB, immI, immS, immU;
    logic [2:0]        f3;
    logic              wordF3;

    // Shared funct3 map, SUB only exists in register form
    function automatic execPkg::aluFunc_t funcOf(input logic [2:0] fn, input logic alt,
                                                 input logic isReg);
        case (fn)
            3'b000:  funcOf = (alt && isReg) ? execPkg::SUB : execPkg::ADD;
            3'b001:  funcOf = execPkg::SLL;
            3'b010:  funcOf = execPkg::SLT;
            3'b011:  funcOf = execPkg::SLTU;
            3'b100:  funcOf = execPkg::XOR;
            3'b101:  funcOf = alt ? execPkg::SRA : execPkg::SRL;
            3'b110:  funcOf = execPkg::OR;
            default: funcOf = execPkg::AND;
        endcase
    endfunction

    assign f3     = instr[14:12];
    assign wordF3 = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b101);
    assign immI   = {{(`EXEC_XLEN-12){instr[31]}}, instr[31:20]};
    assign immS   = {{(`EXEC_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign immU   = {{(`EXEC_XLEN-32){instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        nOp   = execPkg::NOP;
        nFunc = execPkg::ADD;
        nSrcA = rs1Val;
        nSrcB = rs2Val;
        case (instr[6:0])
            7'b0110011: begin
                if (instr[31:25] == 7'b0000001) begin
                    if (f3 == 3'b000) begin
                        nOp   = execPkg::MUL;
                        nFunc = execPkg::MULLO;
                    end
                end else begin
                    nOp   = execPkg::ALU;
                    nFunc = funcOf(f3, instr[30], 1'b1);
                end
            end
            7'b0010011: begin
                nOp   = execPkg::ALUI;
                nFunc = funcOf(f3, instr[30], 1'b0);
                nSrcB = immI;
            end
            7'b0111011: begin
                if (wordF3) begin
                    nOp   = execPkg::ALUW;
                    nFunc = funcOf(f3, instr[30], 1'b1);
                end
            end
            7'b0011011: begin
                if (wordF3) begin
                    nOp   = execPkg::ALUIW;
                    nFunc = funcOf(f3, instr[30], 1'b0);
                    nSrcB = immI;
                end
            end
            7'b0110111: begin
                nOp   = execPkg::LUI;
                nFunc = execPkg::PASSB;
                nSrcB = immU;
            end
            7'b1101111, 7'b1100111: begin
                nOp   = instr[3] ? execPkg::JAL : execPkg::JALR;
                nSrcA = pc;                     // Link value pc plus 4 comes from the ALU
                nSrcB = execPkg::word_t'(4);
            end
            7'b1100011: begin
                nFunc = execPkg::SEQ;
                if (f3 == 3'b000) nOp = execPkg::BZ;
                else if (f3 == 3'b001) nOp = execPkg::BNZ;
            end
            7'b0000011: begin
                if (f3 == 3'b011) nOp = execPkg::LOAD;
                nSrcB = immI;
            end
            7'b0100011: begin
                if (f3 == 3'b011) nOp = execPkg::STORE;
                nSrcB = immS;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end else if (!stall) begin
            dValid <= inValid && (nOp != execPkg::NOP); // Unknown opcodes drop out here
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dPc      <= pc;
            dInstr   <= instr;
            dOp      <= nOp;
            dAluFunc <= nFunc;
            dSrcA    <= nSrcA;
            dSrcB    <= nSrcB;
            dRs1     <= rs1Val;
            dRs2     <= rs2Val;
            dDst     <= dst;
        end
    end

endmodule

// ==== execPkg.sv ====
`include "exec_config.svh"

package execPkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;   // Operands, results, addresses and pc
    typedef logic [`EXEC_ILEN-1:0] u32;      // Raw instruction word
    typedef logic [4:0]            regIdx_t; // Destination register index

    // ==================================================
    // Operation classes seen by execute and memory
    // ==================================================
    typedef enum logic [3:0] {
        NOP,
        ALU,
        ALUI,
        ALUW,
        ALUIW,
        LUI,
        JAL,
        JALR,
        BZ,     // Taken on equal
        BNZ,    // Taken on not equal
        LOAD,
        STORE,
        MUL
    } opClass_t;

    // MULLO returns the low half of the product
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU, SEQ,
        PASSB,
        MULLO
    } aluFunc_t;

    typedef enum logic {
        IDLE,
        WAIT    // Request outstanding on the data port
    } memState_t;

endpackage

// ==== execTop.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module execTop (
    input  logic              clk,
    input  logic              reset,
    input  logic              inValid,
    input  execPkg::u32       instr,
    input  execPkg::word_t    pc,
    input  execPkg::word_t    rs1Val,
    input  execPkg::word_t    rs2Val,
    input  execPkg::regIdx_t  dst,
    output logic              inStall,
    output logic              branch,
    output execPkg::word_t    jump,
    output logic              memReq,
    output logic              memWe,
    output execPkg::word_t    memAddr,
    output execPkg::word_t    memWdata,
    input  logic              memAck,
    input  execPkg::word_t    memRdata,
    output logic              wbValid,
    output execPkg::regIdx_t  wbDst,
    output execPkg::word_t    wbResult
);
    logic              dValid, eValid, stope, stopm;
    execPkg::word_t    dPc, dSrcA, dSrcB, dRs1, dRs2, eRs2, eResult;
    execPkg::u32       dInstr;
    execPkg::opClass_t dOp, eOp;
    execPkg::aluFunc_t dAluFunc;
    execPkg::regIdx_t  dDst, eDst;

    assign inStall = stope | stopm;   // Decode holds behind either later stage

    decodeStage decodeInst (
        .clk, .reset, .inValid, .instr, .pc, .rs1Val, .rs2Val, .dst,
        .stall (inStall),
        .dValid, .dPc, .dInstr, .dOp, .dAluFunc, .dSrcA, .dSrcB, .dRs1, .dRs2, .dDst
    );

    executeStage executeInst (
        .clk, .reset, .dValid, .dPc, .dInstr, .dOp, .dAluFunc, .dSrcA, .dSrcB,
        .dRs1, .dRs2, .dDst, .stopm,
        .eValid, .eOp, .eDst, .eRs2, .eResult, .branch, .jump, .stope
    );

    memoryStage memoryInst (
        .clk, .reset, .eValid, .eOp, .eDst, .eRs2, .eResult, .memAck, .memRdata,
        .stopm, .memReq, .memWe, .memAddr, .memWdata, .wbValid, .wbDst, .wbResult
    );

endmodule

// ==== exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// ==================================================
// Datapath widths
// ==================================================
`define EXEC_XLEN 64
`define EXEC_ILEN 32

// ==================================================
// Multiplier timing
// ==================================================
// Cycles the multiplier occupies execute, must be 2 or more
`define EXEC_MUL_CYCLES 4

`endif

// ==== exec_sva.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module execSva (
    input logic             clk,
    input logic             reset,
    input logic             wbValid,
    input logic             memReq,
    input logic             memAck,
    input logic             memWe,
    input execPkg::word_t   memAddr,
    input execPkg::word_t   memWdata,
    input logic             branch,
    input logic             inStall,
    input logic             dValid,
    input execPkg::word_t   dPc,
    input execPkg::u32      dInstr,
    input execPkg::word_t   dSrcA,
    input execPkg::word_t   dSrcB,
    input execPkg::regIdx_t dDst
);
    resetClears: assert property (@(posedge clk) reset |=> !(wbValid || memReq || branch))
        else $error("Valid output high in the cycle after reset");

    reqStable: assert property (@(posedge clk) disable iff (reset)
        memReq && !memAck |=> memReq && $stable(memWe) && $stable(memAddr) && $stable(memWdata))
        else $error("Data port request changed before memAck");

    decodeHold: assert property (@(posedge clk) disable iff (reset)
        inStall |=> $stable(dValid) && $stable(dPc) && $stable(dInstr) && $stable(dSrcA) &&
                    $stable(dSrcB) && $stable(dDst))
        else $error("Decode register changed while inStall was high");
endmodule

bind execTop execSva svaInst (.*);

// ==== executeStage.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module executeStage (
    input  logic              clk,
    input  logic              reset,
    input  logic              dValid,
    input  execPkg::word_t    dPc,
    input  execPkg::u32       dInstr,
    input  execPkg::opClass_t dOp,
    input  execPkg::aluFunc_t dAluFunc,
    input  execPkg::word_t    dSrcA,
    input  execPkg::word_t    dSrcB,
    input  execPkg::word_t    dRs1,
    input  execPkg::word_t    dRs2,
    input  execPkg::regIdx_t  dDst,
    input  logic              stopm,
    output logic              eValid,
    output execPkg::opClass_t eOp,
    output execPkg::regIdx_t  eDst,
    output execPkg::word_t    eRs2,
    output execPkg::word_t    eResult,
    output logic              branch,
    output execPkg::word_t    jump,
    output logic              stope
);
    execPkg::word_t aluResult, immJ, immI, immB;
    logic           wordMode, bubble, taken;

    assign wordMode = (dOp == execPkg::ALUW) || (dOp == execPkg::ALUIW);

    aluUnit aluInst (
        .clk      (clk),
        .reset    (reset),
        .a        (dSrcA),
        .b        (dSrcB),
        .aluFunc  (dAluFunc),
        .wordMode (wordMode),
        .opValid  (dValid),
        .result   (aluResult),
        .bubble   (bubble)
    );

    // ==================================================
    // Branch and jump resolution
    // ==================================================
    assign immJ = {{(`EXEC_XLEN-20){dInstr[31]}}, dInstr[19:12], dInstr[20],
                   dInstr[30:21], 1'b0};
    assign immI = {{(`EXEC_XLEN-12){dInstr[31]}}, dInstr[31:20]};
    assign immB = {{(`EXEC_XLEN-12){dInstr[31]}}, dInstr[7], dInstr[30:25],
                   dInstr[11:8], 1'b0};

    // SEQ leaves 1 in bit 0 when the operands match
    assign taken = ((dOp == execPkg::BZ) && aluResult[0]) ||
                   ((dOp == execPkg::BNZ) && !aluResult[0]);

    assign branch = dValid && ((dOp == execPkg::JAL) || (dOp == execPkg::JALR) ||
                               (dOp == execPkg::BZ) || (dOp == execPkg::BNZ));

    always_comb begin
        if (dOp == execPkg::JAL) jump = dPc + immJ;
        else if (dOp == execPkg::JALR) jump = dRs1 + immI;
        else if (taken) jump = dPc + immB;
        else jump = dPc + execPkg::word_t'(4);
    end

    // ==================================================
    // Execute register
    // ==================================================
    assign stope = bubble & dValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            eValid <= 1'b0;
        end else if (!stopm) begin
            eValid <= dValid && !bubble;    // A busy multiplier leaves a bubble behind
        end
    end

    always_ff @(posedge clk) begin
        if (!stopm) begin
            eOp     <= dOp;
            eDst    <= dDst;
            eRs2    <= dRs2;
            eResult <= aluResult;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+.
execPkg.sv
decodeStage.sv
aluUnit.sv
executeStage.sv
memoryStage.sv
execTop.sv
exec_sva.sv
tbExec.sv

// ==== memoryStage.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module memoryStage (
    input  logic              clk,
    input  logic              reset,
    input  logic              eValid,
    input  execPkg::opClass_t eOp,
    input  execPkg::regIdx_t  eDst,
    input  execPkg::word_t    eRs2,
    input  execPkg::word_t    eResult,
    input  logic              memAck,
    input  execPkg::word_t    memRdata,
    output logic              stopm,
    output logic              memReq,
    output logic              memWe,
    output execPkg::word_t    memAddr,
    output execPkg::word_t    memWdata,
    output logic              wbValid,
    output execPkg::regIdx_t  wbDst,
    output execPkg::word_t    wbResult
);
    execPkg::memState_t state;
    logic               isMem;

    assign isMem = eValid && ((eOp == execPkg::LOAD) || (eOp == execPkg::STORE));

    // Execute holds the access until the acknowledge arrives
    assign stopm = (state == execPkg::IDLE) ? isMem : !memAck;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= execPkg::IDLE;
            memReq  <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            case (state)
                execPkg::IDLE: begin
                    wbValid <= eValid && !isMem && (eOp != execPkg::BZ) &&
                               (eOp != execPkg::BNZ);
                    if (isMem) begin
                        memReq <= 1'b1;
                        state  <= execPkg::WAIT;
                    end
                end
                execPkg::WAIT: begin
                    wbValid <= memAck && !memWe;    // Only loads write back
                    if (memAck) begin
                        memReq <= 1'b0;
                        state  <= execPkg::IDLE;
                    end
                end
                default: state <= execPkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == execPkg::IDLE) begin
            wbDst    <= eDst;
            wbResult <= eResult;
            if (isMem) begin
                memWe    <= (eOp == execPkg::STORE);
                memAddr  <= eResult;    // rs1 plus immediate from the ALU
                memWdata <= eRs2;
            end
        end else if (memAck) begin
            wbResult <= memRdata;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tbExec -f filelist.f &&
simOut=$(./obj_dir/VtbExec) &&
echo "$simOut" &&
echo "$simOut" | grep -qx "PASS: all tests" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== tbExec.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module tbExec;
    localparam int INSTR_COUNT  = 64;
    localparam int WORST_CYCLES = 3 + `EXEC_MUL_CYCLES + 8;
    localparam int TIMEOUT_NS   = (INSTR_COUNT * WORST_CYCLES + 100) * 10;

    logic clk, reset, inValid, inStall, branch, memReq, memWe, memAck, wbValid;
    execPkg::u32      instr;
    execPkg::word_t   pc, rs1Val, rs2Val, jump, memAddr, memWdata, memRdata, wbResult;
    execPkg::regIdx_t dst, wbDst;

    execPkg::word_t   expVal[$];
    execPkg::regIdx_t expDst[$];
    int               expCycle[$];
    execPkg::word_t   memModel[execPkg::word_t];
    int               cycle, errors, ackWait;
    logic             memBusy;

    execTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ==================================================
    // Data memory model and write-back monitor
    // ==================================================
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (reset) begin
                memAck  = 1'b0;
                memBusy = 1'b0;
            end else if (memAck) begin
                memAck = 1'b0;
            end else if (memReq) begin
                if (!memBusy) begin
                    memBusy = 1'b1;
                    ackWait = $urandom % 4;  // Acknowledge after 0 to 3 cycles
                end
                if (ackWait == 0) begin
                    memAck  = 1'b1;
                    memBusy = 1'b0;
                    if (memWe) memModel[memAddr] = memWdata;
                    else if (memModel.exists(memAddr)) memRdata = memModel[memAddr];
                    else memRdata = memAddr ^ {memAddr[31:0], memAddr[63:32]} ^ 64'h5a5a;
                end else begin
                    ackWait = ackWait - 1;
                end
            end
        end
    end

    always @(negedge clk) begin
        execPkg::word_t   v;
        execPkg::regIdx_t d;
        int               c;
        if (!reset && wbValid) begin
            assert (expVal.size() != 0) else begin
                errors++;
                $display("ERROR %0t: write-back arrived with no instruction outstanding", $time);
            end
            if (expVal.size() != 0) begin
                v = expVal.pop_front();
                d = expDst.pop_front();
                c = expCycle.pop_front();
                assert (wbResult === v) else begin
                    errors++;
                    $display("ERROR %0t: wbResult expected %h actual %h", $time, v, wbResult);
                end
                assert (wbDst === d) else begin
                    errors++;
                    $display("ERROR %0t: wbDst expected %0d actual %0d", $time, d, wbDst);
                end
                if (c >= 0) begin
                    assert (cycle == c) else begin
                        errors++;
                        $display("ERROR %0t: write-back cycle expected %0d actual %0d",
                                 $time, c, cycle);
                    end
                end
            end
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic execPkg::word_t aluExpect(input logic [2:0] f3, input logic alt,
                                                 input execPkg::word_t a, input execPkg::word_t b,
                                                 input logic word);
        execPkg::word_t r;
        logic [31:0]    w;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[5:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: r = (a < b) ? 64'd1 : 64'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[5:0];
                else r = a >> b[5:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (word) begin
            if (f3 == 3'd0) w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            else if (f3 == 3'd1) w = a[31:0] << b[4:0];
            else if (alt) w = $signed(a[31:0]) >>> b[4:0];
            else w = a[31:0] >> b[4:0];
            r = {{32{w[31]}}, w};
        end
        return r;
    endfunction

    // Called just after a rising edge and returns just after the accepting edge
    task automatic sendInstr(input execPkg::u32 i, input execPkg::word_t p, input execPkg::word_t a,
                             input execPkg::word_t b, input execPkg::regIdx_t d,
                             input logic hasWb, input execPkg::word_t v, input logic timed);
        instr   = i;
        pc      = p;
        rs1Val  = a;
        rs2Val  = b;
        dst     = d;
        inValid = 1'b1;
        @(negedge clk);
        while (inStall) @(negedge clk);
        @(posedge clk);
        #1;
        inValid = 1'b0;
        if (hasWb) begin
            expVal.push_back(v);
            expDst.push_back(d);
            expCycle.push_back(timed ? cycle + 2 : -1);
        end
    endtask

    task automatic sendRandomAlu(input logic timed);
        int               kind;
        logic [2:0]       f3;
        logic             alt;
        logic [11:0]      imm;
        logic [19:0]      immU;
        logic [6:0]       op;
        execPkg::word_t   a, b, v;
        execPkg::u32      i;
        execPkg::regIdx_t d;
        kind = $urandom % 5;     // R, I, R word, I word, LUI
        a    = {$urandom, $urandom};
        b    = {$urandom, $urandom};
        d    = $urandom % 32;
        f3   = $urandom % 8;
        if (kind == 2 || kind == 3) f3 = ($urandom % 2) ? 3'd1 : (($urandom % 2) ? 3'd5 : 3'd0);
        alt  = ((f3 == 3'd0 && (kind == 0 || kind == 2)) || f3 == 3'd5) ? $urandom % 2 : 1'b0;
        imm  = $urandom;
        if (f3 == 3'd1 || f3 == 3'd5)
            imm = {1'b0, alt, 4'b0, (kind == 3) ? 1'b0 : imm[5], imm[4:0]};
        op   = (kind == 0) ? 7'b0110011 : (kind == 1) ? 7'b0010011 :
               (kind == 2) ? 7'b0111011 : 7'b0011011;
        if (kind == 4) begin
            immU = $urandom;
            i    = {immU, d, 7'b0110111};
            v    = {{32{immU[19]}}, immU, 12'b0};
        end else if (kind == 0 || kind == 2) begin
            i = {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, d, op};
            v = aluExpect(f3, alt, a, b, kind == 2);
        end else begin
            i = {imm, 5'd1, f3, d, op};
            v = aluExpect(f3, alt, a, {{52{imm[11]}}, imm}, kind == 3);
        end
        sendInstr(i, 64'h1000, a, b, d, 1'b1, v, timed);
    endtask

    task automatic drainPipe();
        repeat (4) @(negedge clk);
        while (expVal.size() != 0 || memReq) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic testAluStream();
        repeat (16) sendRandomAlu(1'b1);     // Back to back, one per cycle
        drainPipe();
    endtask

    task automatic testBranches();
        logic [20:0]      immJ;
        logic [12:0]      immB;
        logic [11:0]      immI;
        execPkg::word_t   p, a, b, tgt;
        execPkg::u32      i;
        execPkg::regIdx_t d;
        for (int j = 0; j < 8; j++) begin
            p    = {$urandom, $urandom} & ~64'h3;
            a    = {$urandom, $urandom};
            b    = ($urandom % 2) ? a : {$urandom, $urandom};
            d    = 5'd1 + ($urandom % 31);
            immJ = $urandom & ~21'h1;
            immB = $urandom & ~13'h1;
            immI = $urandom;
            case (j % 4)
                0: begin
                    i   = {immJ[20], immJ[10:1], immJ[11], immJ[19:12], d, 7'b1101111};
                    tgt = p + {{43{immJ[20]}}, immJ};
                end
                1: begin
                    i   = {immI, 5'd1, 3'b000, d, 7'b1100111};
                    tgt = a + {{52{immI[11]}}, immI};
                end
                default: begin
                    i   = {immB[12], immB[10:5], 5'd2, 5'd1, (j % 4 == 3) ? 3'b001 : 3'b000,
                           immB[4:1], immB[11], 7'b1100011};
                    tgt = (((j % 4) == 2) == (a == b)) ? p + {{51{immB[12]}}, immB} : p + 64'd4;
                end
            endcase
            sendInstr(i, p, a, b, d, (j % 4) < 2, p + 64'd4, 1'b1);
            assert (branch === 1'b1) else begin
                errors++;
                $display("ERROR %0t: branch expected 1 actual %b", $time, branch);
            end
            assert (jump === tgt) else begin
                errors++;
                $display("ERROR %0t: jump expected %h actual %h", $time, tgt, jump);
            end
        end
        drainPipe();
    endtask

    task automatic testMultiply();
        execPkg::word_t a, b;
        repeat (2) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom};
            sendInstr({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd9, 7'b0110011}, 64'h2000, a, b,
                      5'd9, 1'b1, a * b, 1'b0);
            repeat (`EXEC_MUL_CYCLES - 1) begin
                @(negedge clk);
                assert (inStall === 1'b1) else begin
                    errors++;
                    $display("ERROR %0t: inStall expected 1 actual %b", $time, inStall);
                end
            end
            @(posedge clk);
            #1;
            sendRandomAlu(1'b0);    // Must write back after the product
        end
        drainPipe();
    endtask

    task automatic testLoadStore();
        execPkg::word_t addrs[3], datas[3], base;
        logic [11:0]    imm, imm2;
        for (int j = 0; j < 3; j++) begin
            base     = {$urandom, $urandom} & ~64'h7;
            imm      = $urandom & 12'hff8;
            imm2     = $urandom & 12'hff8;
            datas[j] = {$urandom, $urandom};
            addrs[j] = base + {{52{imm[11]}}, imm};
            sendInstr({imm[11:5], 5'd2, 5'd1, 3'b011, imm[4:0], 7'b0100011}, 64'h3000, base,
                      datas[j], 5'd0, 1'b0, '0, 1'b0);
            sendRandomAlu(1'b0);
            sendInstr({imm2, 5'd1, 3'b011, 5'd7, 7'b0000011}, 64'h3004,
                      addrs[j] - {{52{imm2[11]}}, imm2}, '0, 5'd7, 1'b1, datas[j], 1'b0);
            sendRandomAlu(1'b0);
        end
        drainPipe();
        for (int j = 0; j < 3; j++) begin
            assert (memModel.exists(addrs[j])) else begin
                errors++;
                $display("ERROR %0t: no store reached memory address %h", $time, addrs[j]);
            end
            if (memModel.exists(addrs[j])) begin
                assert (memModel[addrs[j]] === datas[j]) else begin
                    errors++;
                    $display("ERROR %0t: memModel[%h] expected %h actual %h",
                             $time, addrs[j], datas[j], memModel[addrs[j]]);
                end
            end
        end
    endtask

    task automatic testMidReset();
        sendRandomAlu(1'b0);
        sendInstr({12'h010, 5'd1, 3'b011, 5'd0, 7'b0100011}, 64'h4000, 64'h8000, 64'h77,
                  5'd0, 1'b0, '0, 1'b0);
        sendInstr({1'b0, 10'd8, 1'b0, 8'd0, 5'd3, 7'b1101111}, 64'h4004, '0, '0, 5'd3,
                  1'b1, 64'h4008, 1'b0);
        reset = 1'b1;
        @(posedge clk);
        #1;
        assert (wbValid === 1'b0 && memReq === 1'b0 && branch === 1'b0) else begin
            errors++;
            $display("ERROR %0t: wbValid/memReq/branch expected 0 actual %b/%b/%b",
                     $time, wbValid, memReq, branch);
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        expVal.delete();             // Work in flight is discarded by reset
        expDst.delete();
        expCycle.delete();
        repeat (4) sendRandomAlu(1'b1);
        drainPipe();
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        void'($urandom(32'hc5252228));
        reset    = 1'b1;
        inValid  = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1Val   = '0;
        rs2Val   = '0;
        dst      = '0;
        memAck   = 1'b0;
        memRdata = '0;
        memBusy  = 1'b0;
        ackWait  = 0;
        cycle    = 0;
        errors   = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        testAluStream();
        testBranches();
        testMultiply();
        testLoadStore();
        testMidReset();
        assert (expVal.size() == 0) else begin
            errors++;
            $display("Run ended with %0d write-backs that never arrived", expVal.size());
        end
        $display("Tests done, errors: %0d", errors);
        if (errors == 0) $display("PASS: all tests");
        else $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("Tests done, errors: %0d", errors);
        $display("FAIL: see errors above");
        $finish;
    end
endmodule
